/* lcd_video_top.f */
logic/lcd_pkg.sv
logic/video_timing.sv
logic/pixel_fifo.sv
logic/spi_byte_tx.sv
logic/lcd_controller.sv
logic/lcd_video_top.sv
verif/clock_gen.sv
verif/lcd_video_properties.sv
verif/lcd_video_tb.sv

/* logic/lcd_controller.sv */
`timescale 1ns/100ps

module lcd_controller #(
  parameter int unsigned wait_cycles = 15000000
) (
  input  logic                                 clk_lcd,
  input  logic                                 rst_n,
  input  logic                                 empty,
  input  logic [lcd_pkg::COLOR_BITS-1:0]       rd_color,
  input  logic                                 rd_first,
  output logic                                 pop,
  input  logic                                 busy,
  input  logic                                 done,
  output logic                                 start,
  output logic [$bits(lcd_pkg::lcd_cmd_t)-1:0] tx_byte,
  output logic                                 dc,
  output logic                                 spi_resn
);
  import lcd_pkg::*;

  lcd_state_t                      state;
  logic [31:0]                     dly_cnt;
  logic [3:0]                      step;
  logic                            pending; // Byte issued, waiting for done
  logic                            half;    // Low byte still to send
  logic [7:0]                      lo_byte;
  logic [$clog2(FRAME_PIXELS)-1:0] pix_cnt;
  logic [8:0]                      init_item;
  logic [8:0]                      win_item;
  logic                            take_pixel;

  // {dc, byte} of each init step
  function automatic logic [8:0] init_rom(input logic [3:0] idx);
    logic [8:0] item;
    case (idx)
      4'd0:    item = {1'b0, SWRESET};
      4'd1:    item = {1'b0, SLPOUT};
      4'd2:    item = {1'b0, MADCTL};
      4'd3:    item = {1'b1, MADCTL_VAL};
      4'd4:    item = {1'b0, COLMOD};
      4'd5:    item = {1'b1, COLMOD_VAL};
      default: item = {1'b0, DISPON};
    endcase
    return item;
  endfunction

  // Full-screen window then memory write
  function automatic logic [8:0] win_rom(input logic [3:0] idx);
    logic [8:0] item;
    case (idx)
      4'd0:    item = {1'b0, CASET};
      4'd4:    item = {1'b1, 8'(X_SIZE - 1)};
      4'd5:    item = {1'b0, RASET};
      4'd9:    item = {1'b1, 8'(Y_SIZE - 1)};
      4'd10:   item = {1'b0, RAMWR};
      default: item = {1'b1, 8'h00};
    endcase
    return item;
  endfunction

  assign init_item = init_rom(step);
  assign win_item  = win_rom(step);

  assign take_pixel = (state == STREAM) && !pending && !busy && !half && !empty;

  // Discard stale items until the frame marker shows up
  assign pop = take_pixel || ((state == WAIT_FRAME) && !empty && !rd_first);

  always_ff @(posedge clk_lcd) begin
    if (!rst_n) begin
      state    <= RESET_LOW;
      dly_cnt  <= '0;
      step     <= '0;
      pending  <= 1'b0;
      half     <= 1'b0;
      pix_cnt  <= '0;
      start    <= 1'b0;
      tx_byte  <= '0;
      dc       <= 1'b0;
      spi_resn <= 1'b0;
    end else begin
      start <= 1'b0;
      case (state)
        RESET_LOW: begin
          if (dly_cnt == RESET_CYCLES - 1) begin
            dly_cnt  <= '0;
            spi_resn <= 1'b1;
            state    <= RESET_WAIT;
          end else begin
            dly_cnt <= dly_cnt + 1'b1;
          end
        end
        RESET_WAIT: begin
          if (dly_cnt == wait_cycles - 1) begin
            dly_cnt <= '0;
            state   <= INIT_SEND;
          end else begin
            dly_cnt <= dly_cnt + 1'b1;
          end
        end
        INIT_SEND: begin
          if (!busy) begin
            start         <= 1'b1;
            {dc, tx_byte} <= init_item;
            state         <= INIT_WAIT;
          end
        end
        INIT_WAIT: begin
          if (done) begin
            if (step == 4'd6) begin // DISPON sent
              step  <= '0;
              state <= WAIT_FRAME;
            end else begin
              step  <= step + 1'b1;
              state <= (step < 4'd2) ? RESET_WAIT : INIT_SEND; // Delay after SWRESET, SLPOUT
            end
          end
        end
        WAIT_FRAME: begin
          if (!empty && rd_first) begin
            step  <= '0;
            state <= WINDOW;
          end
        end
        WINDOW: begin
          if (pending) begin
            if (done) begin
              pending <= 1'b0;
              if (step == 4'd10) begin
                step    <= '0;
                half    <= 1'b0;
                pix_cnt <= '0;
                state   <= STREAM;
              end else begin
                step <= step + 1'b1;
              end
            end
          end else if (!busy) begin
            start         <= 1'b1;
            {dc, tx_byte} <= win_item;
            pending       <= 1'b1;
          end
        end
        STREAM: begin
          if (pending) begin
            if (done) begin
              pending <= 1'b0;
              if (!half) begin // Low byte finished the pixel
                if (pix_cnt == $bits(pix_cnt)'(FRAME_PIXELS - 1)) begin
                  pix_cnt <= '0;
                  state   <= WAIT_FRAME;
                end else begin
                  pix_cnt <= pix_cnt + 1'b1;
                end
              end
            end
          end else if (take_pixel) begin
            start   <= 1'b1;
            dc      <= 1'b1;
            tx_byte <= rd_color[COLOR_BITS-1 -: 8];
            lo_byte <= rd_color[7:0];
            half    <= 1'b1;
            pending <= 1'b1;
          end else if (half && !busy) begin
            start   <= 1'b1;
            dc      <= 1'b1;
            tx_byte <= lo_byte;
            half    <= 1'b0;
            pending <= 1'b1;
          end
        end
        default: state <= RESET_LOW;
      endcase
    end
  end

endmodule

/* logic/lcd_pkg.sv */
package lcd_pkg;

  // Visible panel area
  localparam int X_SIZE = 240;
  localparam int Y_SIZE = 240;
  localparam int COLOR_BITS = 16; // RGB565

  // Horizontal timing in pixel strobes
  localparam int H_FRONT = 8;
  localparam int H_SYNC = 4;
  localparam int H_BACK = 8;
  localparam int H_TOTAL = X_SIZE + H_FRONT + H_SYNC + H_BACK;

  // Vertical timing in lines
  localparam int V_FRONT = 1;
  localparam int V_SYNC = 1;
  localparam int V_BACK = 1;
  localparam int V_TOTAL = Y_SIZE + V_FRONT + V_SYNC + V_BACK;

  localparam int X_BITS = 9;
  localparam int Y_BITS = 9;
  localparam int FRAME_PIXELS = X_SIZE * Y_SIZE;

  localparam int FIFO_DEPTH = 16;

  localparam int BYTE_CYCLES = 16;    // 8 bits, 2 clocks each
  localparam int RESET_CYCLES = 1250; // 10 us at 125 MHz

  typedef enum logic [7:0] {
    SWRESET = 8'h01,
    SLPOUT  = 8'h11,
    DISPON  = 8'h29,
    CASET   = 8'h2A,
    RASET   = 8'h2B,
    RAMWR   = 8'h2C,
    MADCTL  = 8'h36,
    COLMOD  = 8'h3A
  } lcd_cmd_t;

  localparam logic [7:0] MADCTL_VAL = 8'h00;
  localparam logic [7:0] COLMOD_VAL = 8'h55; // 16-bit color

  typedef enum logic [2:0] {
    RESET_LOW,
    RESET_WAIT,
    INIT_SEND,
    INIT_WAIT,
    WAIT_FRAME,
    WINDOW,
    STREAM
  } lcd_state_t;

endpackage

/* logic/lcd_video_top.sv */
`timescale 1ns/100ps

module lcd_video_top #(
  parameter int unsigned wait_cycles = 15000000
) (
  input  logic clk_lcd,
  input  logic rst_n,
  input  logic pixel_ena,
  output logic spi_clk,
  output logic spi_mosi,
  output logic spi_dc,
  output logic spi_resn,
  output logic spi_csn,
  output logic overflow
);
  import lcd_pkg::*;

  logic [COLOR_BITS-1:0]     color;
  logic [COLOR_BITS-1:0]     rd_color;
  logic                      blank;
  logic                      first;
  logic                      fifo_wr;
  logic                      rd_first;
  logic                      empty;
  logic                      pop;
  logic                      busy;
  logic                      done;
  logic                      start;
  logic                      dc;
  logic [$bits(lcd_cmd_t)-1:0] tx_byte;

  video_timing video_timing_i (
    .clk_lcd   (clk_lcd),
    .rst_n     (rst_n),
    .pixel_ena (pixel_ena),
    .color     (color),
    .blank     (blank),
    .hsync     (),
    .vsync     (),
    .first     (first)
  );

  assign fifo_wr = pixel_ena && !blank; // Visible pixels only

  pixel_fifo pixel_fifo_i (
    .clk_lcd  (clk_lcd),
    .rst_n    (rst_n),
    .wr       (fifo_wr),
    .wr_color (color),
    .wr_first (first),
    .pop      (pop),
    .rd_color (rd_color),
    .rd_first (rd_first),
    .empty    (empty),
    .overflow (overflow)
  );

  lcd_controller #(
    .wait_cycles (wait_cycles)
  ) lcd_controller_i (
    .clk_lcd  (clk_lcd),
    .rst_n    (rst_n),
    .empty    (empty),
    .rd_color (rd_color),
    .rd_first (rd_first),
    .pop      (pop),
    .busy     (busy),
    .done     (done),
    .start    (start),
    .tx_byte  (tx_byte),
    .dc       (dc),
    .spi_resn (spi_resn)
  );

  spi_byte_tx spi_byte_tx_i (
    .clk_lcd  (clk_lcd),
    .rst_n    (rst_n),
    .start    (start),
    .tx_byte  (tx_byte),
    .dc       (dc),
    .busy     (busy),
    .done     (done),
    .spi_clk  (spi_clk),
    .spi_mosi (spi_mosi),
    .spi_dc   (spi_dc)
  );

  assign spi_csn = 1'b0; // Single panel, always selected

endmodule

/* logic/pixel_fifo.sv */
`timescale 1ns/100ps

module pixel_fifo (
  input  logic                           clk_lcd,
  input  logic                           rst_n,
  input  logic                           wr,
  input  logic [lcd_pkg::COLOR_BITS-1:0] wr_color,
  input  logic                           wr_first,
  input  logic                           pop,
  output logic [lcd_pkg::COLOR_BITS-1:0] rd_color,
  output logic                           rd_first,
  output logic                           empty,
  output logic                           overflow
);
  import lcd_pkg::*;

  logic [COLOR_BITS:0]                 mem [FIFO_DEPTH]; // Marker bit on top
  logic [$clog2(FIFO_DEPTH)-1:0]       wptr;
  logic [$clog2(FIFO_DEPTH)-1:0]       rptr;
  logic [$clog2(FIFO_DEPTH + 1)-1:0]   count;
  logic                                full;
  logic                                do_wr;
  logic                                do_rd;

  assign full  = (count == FIFO_DEPTH);
  assign empty = (count == '0);
  assign do_wr = wr && !full;
  assign do_rd = pop && !empty;

  always_ff @(posedge clk_lcd) begin
    if (do_wr) begin
      mem[wptr] <= {wr_first, wr_color};
    end
  end

  always_ff @(posedge clk_lcd) begin
    if (!rst_n) begin
      wptr     <= '0;
      rptr     <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (do_wr) wptr <= wptr + 1'b1;
      if (do_rd) rptr <= rptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      if (wr && full) overflow <= 1'b1; // Sticky until reset
    end
  end

  assign {rd_first, rd_color} = mem[rptr];

endmodule

/* logic/spi_byte_tx.sv */
`timescale 1ns/100ps

module spi_byte_tx (
  input  logic                                 clk_lcd,
  input  logic                                 rst_n,
  input  logic                                 start,
  input  logic [$bits(lcd_pkg::lcd_cmd_t)-1:0] tx_byte,
  input  logic                                 dc,
  output logic                                 busy,
  output logic                                 done,
  output logic                                 spi_clk,
  output logic                                 spi_mosi,
  output logic                                 spi_dc
);
  import lcd_pkg::*;

  logic [$bits(lcd_cmd_t)-1:0]    shreg;
  logic [$clog2(BYTE_CYCLES)-1:0] cnt;

  always_ff @(posedge clk_lcd) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      cnt     <= '0;
      spi_clk <= 1'b1; // Mode 3 idles high
      spi_dc  <= 1'b0;
      shreg   <= '0;
    end else if (!busy) begin
      if (start) begin
        busy    <= 1'b1;
        cnt     <= '0;
        spi_clk <= 1'b0; // MSB already on the line
        shreg   <= tx_byte;
        spi_dc  <= dc;
      end
    end else begin
      cnt <= cnt + 1'b1;
      if (!cnt[0]) begin
        spi_clk <= 1'b1; // Panel samples here
      end else if (done) begin
        busy <= 1'b0;
      end else begin
        spi_clk <= 1'b0;
        shreg   <= shreg << 1;
      end
    end
  end

  // Last high phase of bit 0
  assign done     = busy && (cnt == $bits(cnt)'(BYTE_CYCLES - 1));
  assign spi_mosi = shreg[$high(shreg)];

endmodule

/* logic/video_timing.sv */
`timescale 1ns/100ps

module video_timing (
  input  logic                           clk_lcd,
  input  logic                           rst_n,
  input  logic                           pixel_ena,
  output logic [lcd_pkg::COLOR_BITS-1:0] color,
  output logic                           blank,
  output logic                           hsync,
  output logic                           vsync,
  output logic                           first
);
  import lcd_pkg::*;

  logic [X_BITS-1:0] hcnt;
  logic [Y_BITS-1:0] vcnt;
  logic [7:0]        xv;
  logic [7:0]        yv;
  logic [7:0]        xy;

  always_ff @(posedge clk_lcd) begin
    if (!rst_n) begin
      hcnt <= '0;
      vcnt <= '0;
    end else if (pixel_ena) begin
      if (hcnt == X_BITS'(H_TOTAL - 1)) begin
        hcnt <= '0;
        if (vcnt == Y_BITS'(V_TOTAL - 1)) begin
          vcnt <= '0;
        end else begin
          vcnt <= vcnt + 1'b1;
        end
      end else begin
        hcnt <= hcnt + 1'b1;
      end
    end
  end

  assign blank = (hcnt >= X_BITS'(X_SIZE)) || (vcnt >= Y_BITS'(Y_SIZE));

  // Active high sync pulses after the front porch
  assign hsync = (hcnt >= X_BITS'(X_SIZE + H_FRONT)) &&
                 (hcnt < X_BITS'(X_SIZE + H_FRONT + H_SYNC));
  assign vsync = (vcnt >= Y_BITS'(Y_SIZE + V_FRONT)) &&
                 (vcnt < Y_BITS'(Y_SIZE + V_FRONT + V_SYNC));

  assign first = (hcnt == '0) && (vcnt == '0);

  // Visible coordinates fit in 8 bits
  assign xv = hcnt[7:0];
  assign yv = vcnt[7:0];
  assign xy = xv ^ yv;

  assign color = {xv[7:3], yv[7:2], xy[7:3]}; // R5 G6 B5

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it, exit status follows the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f lcd_video_top.f \
  --top-module lcd_video_tb -o lcd_video_sim &&
./obj_dir/lcd_video_sim ||
{ echo "Simulation failed"; exit 1; }

/* verif/clock_gen.sv */
`timescale 1ns/100ps

module clock_gen (
  input  logic reset_req,
  output logic clk_lcd,
  output logic rst_n
);

  localparam int PERIOD_NS = 8;
  localparam int RESET_LEN = 2;

  logic [1:0] rst_cnt = '0;

  initial begin
    clk_lcd = 1'b0;
    forever #(PERIOD_NS / 2) clk_lcd = ~clk_lcd;
  end

  // Counts falling edges since power-up or the last request
  always @(negedge clk_lcd) begin
    if (reset_req) begin
      rst_cnt <= '0;
    end else if (rst_cnt != 2'(RESET_LEN)) begin
      rst_cnt <= rst_cnt + 1'b1;
    end
  end

  assign rst_n = (rst_cnt == 2'(RESET_LEN));

endmodule

/* verif/lcd_video_properties.sv */
`timescale 1ns/100ps

module lcd_video_properties (
  input logic clk_lcd,
  input logic rst_n,
  input logic spi_clk,
  input logic spi_mosi,
  input logic busy,
  input logic pop,
  input logic empty
);

  clk_idle_high: assert property (@(posedge clk_lcd) disable iff (!rst_n)
    !busy |-> spi_clk)
    else $error("spi_clk low while no byte is in progress");

  // Data may only move together with or after the falling spi_clk edge
  mosi_stable: assert property (@(posedge clk_lcd) disable iff (!rst_n)
    !$stable(spi_mosi) |-> !spi_clk)
    else $error("spi_mosi changed while spi_clk was high");

  pop_not_empty: assert property (@(posedge clk_lcd) disable iff (!rst_n)
    pop |-> !empty)
    else $error("FIFO pop while empty");

endmodule

/* verif/lcd_video_tb.sv */
`timescale 1ns/100ps

module lcd_video_tb;
  import lcd_pkg::*;

  localparam int unsigned WAIT_CYCLES = 200;
  localparam int BYTE_TIMEOUT = 100000; // Covers vertical blanking
  localparam int SEED = 75;

  logic       clk_lcd;
  logic       rst_n;
  logic       reset_req = 1'b0;
  logic       pixel_ena = 1'b0;
  logic       spi_clk;
  logic       spi_mosi;
  logic       spi_dc;
  logic       spi_resn;
  logic       spi_csn;
  logic       overflow;
  int         pix_mode = 0;    // 0 idle, 1 random gaps, 2 every cycle
  int         gap = 0;
  logic       clk_prev = 1'b1;
  logic [7:0] shift = '0;
  int         bit_cnt = 0;
  int         early_edges = 0;
  logic [8:0] byte_q[$];       // {dc, byte} in arrival order

  clock_gen clock_gen_i (.reset_req(reset_req), .clk_lcd(clk_lcd), .rst_n(rst_n));

  lcd_video_top #(.wait_cycles(WAIT_CYCLES)) dut_i (
    .clk_lcd   (clk_lcd),
    .rst_n     (rst_n),
    .pixel_ena (pixel_ena),
    .spi_clk   (spi_clk),
    .spi_mosi  (spi_mosi),
    .spi_dc    (spi_dc),
    .spi_resn  (spi_resn),
    .spi_csn   (spi_csn),
    .overflow  (overflow)
  );

  bind lcd_video_top lcd_video_properties props_i (
    .clk_lcd  (clk_lcd),
    .rst_n    (rst_n),
    .spi_clk  (spi_clk),
    .spi_mosi (spi_mosi),
    .busy     (busy),
    .pop      (pop),
    .empty    (empty)
  );

  always @(negedge clk_lcd) begin
    if (pix_mode == 2) begin
      pixel_ena = 1'b1;
    end else if (pix_mode == 1 && gap == 0) begin
      pixel_ena = 1'b1;
      gap = $urandom_range(60, 40);
    end else begin
      pixel_ena = 1'b0;
      if (gap > 0) gap--;
    end
  end

  // Takes a bit at the first falling clk_lcd edge after spi_clk rises
  always @(negedge clk_lcd) begin
    if (!spi_resn) begin
      bit_cnt = 0;
      if (spi_clk && !clk_prev) early_edges++;
    end else if (spi_clk && !clk_prev) begin
      shift = {shift[6:0], spi_mosi};
      bit_cnt++;
      if (bit_cnt == 8) begin
        byte_q.push_back({spi_dc, shift});
        bit_cnt = 0;
      end
    end
    clk_prev = spi_clk;
  end

  // Test picture rule on visible coordinates
  function automatic logic [COLOR_BITS-1:0] picture_color(input logic [7:0] x,
                                                          input logic [7:0] y);
    logic [7:0] b;
    b = x ^ y;
    return {x[7:3], y[7:2], b[7:3]};
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "Run aborted");
  endtask

  task automatic report_mismatch(input string msg);
    abort_run($sformatf("FAILED at %0t ns: %s", $time, msg));
  endtask

  task automatic check_level(input string what, input logic got, input logic exp);
    if (got !== exp) report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
  endtask

  task automatic check_cmd(input lcd_cmd_t exp, input logic [7:0] got, input logic got_dc);
    if (got !== exp || got_dc !== 1'b0) begin
      report_mismatch($sformatf("byte %02h dc %b, expected command %s (%02h) dc 0",
                                got, got_dc, exp.name(), exp));
    end
  endtask

  task automatic check_data(input logic [7:0] exp, input logic [7:0] got, input logic got_dc);
    if (got !== exp || got_dc !== 1'b1) begin
      report_mismatch($sformatf("byte %02h dc %b, expected argument %02h dc 1",
                                got, got_dc, exp));
    end
  endtask

  task automatic check_pixel(input int x, input int y, input logic [COLOR_BITS-1:0] exp,
                             input logic [COLOR_BITS-1:0] got, input logic [1:0] dcs);
    if (got !== exp || dcs !== 2'b11) begin
      report_mismatch($sformatf("pixel (%0d,%0d) is %04h dc %b, expected %04h dc 11",
                                x, y, got, dcs, exp));
    end
  endtask

  task automatic wait_reset(input logic level, input int limit);
    int cycles;
    cycles = 0;
    while (rst_n !== level) begin
      @(posedge clk_lcd);
      cycles++;
      if (cycles > limit) abort_run("Timeout: reset did not change as expected");
    end
  endtask

  task automatic wait_overflow(input int limit);
    int cycles;
    cycles = 0;
    while (overflow !== 1'b1) begin
      @(negedge clk_lcd);
      cycles++;
      if (cycles > limit) abort_run("Timeout: overflow never rose at the full pixel rate");
    end
  endtask

  task automatic next_byte(output logic [7:0] value, output logic dc_level);
    int waited;
    waited = 0;
    while (byte_q.size() == 0) begin
      @(posedge clk_lcd);
      waited++;
      if (waited > BYTE_TIMEOUT) abort_run("Timeout: no SPI byte arrived");
    end
    {dc_level, value} = byte_q.pop_front();
  endtask

  task automatic receive_cmd(input lcd_cmd_t exp);
    logic [7:0] value;
    logic       dc_level;
    next_byte(value, dc_level);
    check_cmd(exp, value, dc_level);
  endtask

  task automatic receive_data(input logic [7:0] exp);
    logic [7:0] value;
    logic       dc_level;
    next_byte(value, dc_level);
    check_data(exp, value, dc_level);
  endtask

  task automatic receive_window();
    receive_cmd(CASET);
    for (int i = 0; i < 3; i++) receive_data(8'h00);
    receive_data(8'(X_SIZE - 1));
    receive_cmd(RASET);
    for (int i = 0; i < 3; i++) receive_data(8'h00);
    receive_data(8'(Y_SIZE - 1));
    receive_cmd(RAMWR);
  endtask

  initial begin : main_seq
    int         cycles;
    logic [7:0] hi;
    logic [7:0] lo;
    logic       dc_hi;
    logic       dc_lo;
    void'($urandom(SEED));
    wait_reset(1'b1, 10);
    @(negedge clk_lcd);
    check_level("spi_resn after reset", spi_resn, 1'b0);
    check_level("spi_csn after reset", spi_csn, 1'b0);
    check_level("spi_clk after reset", spi_clk, 1'b1);
    check_level("spi_dc after reset", spi_dc, 1'b0);
    check_level("overflow after reset", overflow, 1'b0);
    cycles = 1;
    while (!spi_resn) begin
      @(negedge clk_lcd);
      cycles++;
      if (cycles > RESET_CYCLES + 100) abort_run("Timeout: panel reset never released");
    end
    if (cycles < RESET_CYCLES) report_mismatch("spi_resn rose too early");
    if (early_edges != 0 || byte_q.size() != 0) report_mismatch("SPI traffic before spi_resn");
    receive_cmd(SWRESET);
    receive_cmd(SLPOUT);
    receive_cmd(MADCTL);
    receive_data(MADCTL_VAL);
    receive_cmd(COLMOD);
    receive_data(COLMOD_VAL);
    receive_cmd(DISPON);
    pix_mode = 1;
    receive_window();
    for (int y = 0; y < Y_SIZE; y++) begin
      for (int x = 0; x < X_SIZE; x++) begin
        next_byte(hi, dc_hi);
        next_byte(lo, dc_lo);
        check_pixel(x, y, picture_color(8'(x), 8'(y)), {hi, lo}, {dc_hi, dc_lo});
      end
    end
    receive_cmd(CASET); // Next frame follows the last pixel
    @(negedge clk_lcd);
    check_level("overflow at the slow pixel rate", overflow, 1'b0);
    check_level("spi_csn while streaming", spi_csn, 1'b0);
    @(posedge clk_lcd);
    pix_mode = 2;
    wait_overflow(1000);
    reset_req <= 1'b1;
    @(negedge clk_lcd);
    reset_req <= 1'b0;
    wait_reset(1'b0, 4);
    @(negedge clk_lcd);
    check_level("overflow in reset", overflow, 1'b0);
    wait_reset(1'b1, 10);
    wait_overflow(1000);
    repeat (500) begin
      @(negedge clk_lcd);
      check_level("overflow after it was set", overflow, 1'b1);
    end
    $display(">>> PASS");
    $finish;
  end

endmodule
